// File: hdl/cq_request_decoder.sv
// completer request decoder: sop tracking, header decode, rx fsm, completion request

`timescale 1ns/1ps

module cq_request_decoder #(
   parameter int ADDR_W = 11
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  rx_engine_pkg::cq_beat_t   cq_beat_i,
   input  logic                      cq_valid_i,
   output logic                      cq_ready_o,
   output rx_engine_pkg::compl_req_t compl_req_o,
   output logic                      compl_valid_o,
   input  logic                      compl_ready_i,
   output rx_engine_pkg::pay_beat_t  pay_beat_o,
   output logic                      pay_valid_o,
   input  logic                      pay_ready_i
);

   localparam int CPL_W = rx_engine_pkg::CPL_ADDR_W;

   rx_engine_pkg::rx_state_e        state_q;
   logic                            in_pkt_q;       // inside a packet, past its header
   logic                            sop;
   logic                            cq_acc;         // any beat taken
   logic                            hdr_acc;        // header beat taken in idle
   logic                            rd_one;         // single dw memory read
   logic [rx_engine_pkg::LEN_W-1:0] hdr_len;
   rx_engine_pkg::req_type_e        hdr_type;
   logic [ADDR_W-1:0]               hdr_addr;
   rx_engine_pkg::compl_req_t       compl_q;
   logic                            compl_valid_q;

   ///////////////////////////////////////////////////////////////////////
   // framing
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt_q <= 1'b0;
      end else if (cq_acc && cq_beat_i.last) begin
         in_pkt_q <= 1'b0;  // tlast closes the packet
      end else if (sop && cq_ready_o) begin
         in_pkt_q <= 1'b1;
      end
   end

   assign sop     = !in_pkt_q && cq_valid_i;
   assign cq_acc  = cq_valid_i && cq_ready_o;
   assign hdr_acc = sop && cq_ready_o && (state_q == rx_engine_pkg::RX_IDLE);

   // header fields, meaningful only on the first beat
   assign hdr_len  = cq_beat_i.data[rx_engine_pkg::HDR_LEN_LSB +: rx_engine_pkg::LEN_W];
   assign hdr_type = rx_engine_pkg::req_type_e'(cq_beat_i.data[rx_engine_pkg::HDR_TYPE_LSB +: 4]);
   assign hdr_addr = cq_beat_i.data[rx_engine_pkg::HDR_ADDR_LSB +: ADDR_W];
   assign rd_one   = (hdr_type == rx_engine_pkg::REQ_MEM_RD) &&
                     (hdr_len == rx_engine_pkg::LEN_W'(1));

   // ready follows the state, aligner back-pressure whenever it may be fed
   always_comb begin
      case (state_q)
         rx_engine_pkg::RX_RD_WAIT: cq_ready_o = 1'b0;
         rx_engine_pkg::RX_DISCARD: cq_ready_o = 1'b1;
         default:                   cq_ready_o = pay_ready_i;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // receive fsm
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q       <= rx_engine_pkg::RX_IDLE;
         compl_valid_q <= 1'b0;
      end else begin
         case (state_q)
            rx_engine_pkg::RX_IDLE: begin
               if (hdr_acc) begin
                  if (rd_one) begin
                     compl_valid_q <= 1'b1;  // hand off to completion tx
                     state_q       <= rx_engine_pkg::RX_RD_WAIT;
                  end else if (hdr_type == rx_engine_pkg::REQ_MEM_WR) begin
                     if (!cq_beat_i.last) begin
                        state_q <= rx_engine_pkg::RX_WR_PAYLOAD;
                     end
                  end else if (!cq_beat_i.last) begin
                     state_q <= rx_engine_pkg::RX_DISCARD;  // other reads, other types
                  end
               end
            end
            rx_engine_pkg::RX_WR_PAYLOAD,
            rx_engine_pkg::RX_DISCARD: begin
               if (cq_acc && cq_beat_i.last) begin
                  state_q <= rx_engine_pkg::RX_IDLE;
               end
            end
            rx_engine_pkg::RX_RD_WAIT: begin
               if (compl_ready_i) begin
                  compl_valid_q <= 1'b0;
                  state_q       <= rx_engine_pkg::RX_IDLE;
               end
            end
            default: state_q <= rx_engine_pkg::RX_IDLE;
         endcase
      end
   end

   // completion fields, captured with the read header
   always_ff @(posedge clk) begin
      if (hdr_acc && rd_one) begin
         compl_q.tc   <= cq_beat_i.data[rx_engine_pkg::HDR_TC_LSB +: 3];
         compl_q.attr <= cq_beat_i.data[rx_engine_pkg::HDR_ATTR_LSB +: 3];
         compl_q.len  <= hdr_len;
         compl_q.rid  <= cq_beat_i.data[rx_engine_pkg::HDR_RID_LSB +: 16];
         compl_q.tag  <= cq_beat_i.data[rx_engine_pkg::HDR_TAG_LSB +: 8];
         compl_q.be   <= cq_beat_i.byte_en;
         compl_q.addr <= CPL_W'(hdr_addr);
      end
   end

   assign compl_req_o   = compl_q;
   assign compl_valid_o = compl_valid_q;

   ///////////////////////////////////////////////////////////////////////
   // payload stream to the aligner
   ///////////////////////////////////////////////////////////////////////
   assign pay_valid_o = cq_valid_i &&
                        ((state_q == rx_engine_pkg::RX_WR_PAYLOAD) ||
                         (hdr_acc && (hdr_type == rx_engine_pkg::REQ_MEM_WR)));

   assign pay_beat_o.data  = cq_beat_i.data;
   assign pay_beat_o.first = (state_q == rx_engine_pkg::RX_IDLE);  // header beat
   assign pay_beat_o.last  = cq_beat_i.last;
   assign pay_beat_o.len   = hdr_len;

   // request must hold until the completion side takes it
   a_compl_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      compl_valid_o && !compl_ready_i |=> compl_valid_o && $stable(compl_req_o)
   ) else $error("completion request changed before handshake");

endmodule

// File: hdl/rx_engine_pkg.sv
// shared widths, header field offsets, request and state enums, stream structs

package rx_engine_pkg;

   ///////////////////////////////////////////////////////////////////////
   // widths
   ///////////////////////////////////////////////////////////////////////
   localparam int DATA_W     = 256;  // request stream and fifo word
   localparam int DW_W       = 32;
   localparam int LEN_W      = 11;   // dword count field
   localparam int CPL_ADDR_W = 11;   // address carried to the completion side

   ///////////////////////////////////////////////////////////////////////
   // header field positions in the first beat
   ///////////////////////////////////////////////////////////////////////
   localparam int HDR_ADDR_LSB = 2;    // dword address
   localparam int HDR_LEN_LSB  = 64;
   localparam int HDR_TYPE_LSB = 75;   // 4 bit request type
   localparam int HDR_RID_LSB  = 80;   // requester id
   localparam int HDR_TAG_LSB  = 96;
   localparam int HDR_TC_LSB   = 121;
   localparam int HDR_ATTR_LSB = 124;

   // request types we act on, all others are dropped
   typedef enum logic [3:0] {
      REQ_MEM_RD = 4'd0,
      REQ_MEM_WR = 4'd1
   } req_type_e;

   typedef enum logic [1:0] {
      RX_IDLE,        // waiting for a header
      RX_WR_PAYLOAD,  // passing write data to the aligner
      RX_RD_WAIT,     // completion request outstanding
      RX_DISCARD      // swallowing an unsupported packet
   } rx_state_e;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
      logic [7:0]        byte_en;  // last dw be 7:4, first dw be 3:0
   } cq_beat_t;

   typedef struct packed {
      logic [2:0]            tc;
      logic [2:0]            attr;
      logic [LEN_W-1:0]      len;
      logic [15:0]           rid;
      logic [7:0]            tag;
      logic [7:0]            be;
      logic [CPL_ADDR_W-1:0] addr;
   } compl_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              first;  // header beat, dw0..3 in upper half
      logic              last;
      logic [LEN_W-1:0]  len;    // only valid with first
   } pay_beat_t;

endpackage

// File: hdl/rx_engine_top.sv
// rx engine top: request decoder, write payload aligner and throughput meter

`timescale 1ns/1ps

module rx_engine_top #(
   parameter int ADDR_W        = 11,
   parameter int WINDOW_CYCLES = 25000000
) (
   input  logic                             clk,
   input  logic                             rst_n,
   // completer request stream
   input  rx_engine_pkg::cq_beat_t          cq_beat_i,
   input  logic                             cq_valid_i,
   output logic                             cq_ready_o,
   // read completion request
   output rx_engine_pkg::compl_req_t        compl_req_o,
   output logic                             compl_valid_o,
   input  logic                             compl_ready_i,
   // write data fifo
   output logic [rx_engine_pkg::DATA_W-1:0] fifo_word_o,
   output logic                             fifo_valid_o,
   input  logic                             fifo_ready_i,
   // throughput
   input  logic                             meter_clear_i,
   output logic [31:0]                      window_count_o,
   output logic                             window_done_o
);

   rx_engine_pkg::pay_beat_t pay_beat;
   logic                     pay_valid;
   logic                     pay_ready;
   logic                     word_accept;

   assign word_accept = fifo_valid_o && fifo_ready_i;

   cq_request_decoder #(
      .ADDR_W (ADDR_W)
   ) i_cq_request_decoder (
      .clk           (clk),
      .rst_n         (rst_n),
      .cq_beat_i     (cq_beat_i),
      .cq_valid_i    (cq_valid_i),
      .cq_ready_o    (cq_ready_o),
      .compl_req_o   (compl_req_o),
      .compl_valid_o (compl_valid_o),
      .compl_ready_i (compl_ready_i),
      .pay_beat_o    (pay_beat),
      .pay_valid_o   (pay_valid),
      .pay_ready_i   (pay_ready)
   );

   write_payload_aligner i_write_payload_aligner (
      .clk          (clk),
      .rst_n        (rst_n),
      .pay_beat_i   (pay_beat),
      .pay_valid_i  (pay_valid),
      .pay_ready_o  (pay_ready),
      .fifo_word_o  (fifo_word_o),
      .fifo_valid_o (fifo_valid_o),
      .fifo_ready_i (fifo_ready_i)
   );

   throughput_meter #(
      .WINDOW_CYCLES (WINDOW_CYCLES)
   ) i_throughput_meter (
      .clk            (clk),
      .rst_n          (rst_n),
      .meter_clear_i  (meter_clear_i),
      .word_accept_i  (word_accept),
      .window_count_o (window_count_o),
      .window_done_o  (window_done_o)
   );

endmodule

// File: hdl/throughput_meter.sv
// throughput meter: free running window counter, accepted fifo words per window

`timescale 1ns/1ps

module throughput_meter #(
   parameter int WINDOW_CYCLES = 25000000
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        meter_clear_i,
   input  logic        word_accept_i,   // fifo valid and ready
   output logic [31:0] window_count_o,
   output logic        window_done_o
);

   localparam logic [31:0] WIN_LAST = WINDOW_CYCLES;

   logic [31:0] win_cnt_q;   // 0 .. WINDOW_CYCLES
   logic [31:0] word_cnt_q;
   logic [31:0] count_q;     // last finished window
   logic        done_q;
   logic        wrap;

   assign wrap = (win_cnt_q == WIN_LAST);  // boundary cycle

   ///////////////////////////////////////////////////////////////////////
   // window timing
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         win_cnt_q <= '0;
      end else if (meter_clear_i) begin
         win_cnt_q <= '0;
      end else if (wrap) begin
         win_cnt_q <= '0;
      end else begin
         win_cnt_q <= win_cnt_q + 32'd1;
      end
   end

   // word count, snapshot at the wrap
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_cnt_q <= '0;
         count_q    <= '0;
         done_q     <= 1'b0;
      end else if (meter_clear_i) begin
         word_cnt_q <= '0;
         count_q    <= '0;
         done_q     <= 1'b0;
      end else begin
         done_q <= wrap;  // one cycle pulse
         if (wrap) begin
            count_q    <= word_cnt_q;
            word_cnt_q <= {31'd0, word_accept_i};  // boundary accept opens next window
         end else if (word_accept_i) begin
            word_cnt_q <= word_cnt_q + 32'd1;
         end
      end
   end

   assign window_count_o = count_q;
   assign window_done_o  = done_q;

endmodule

// File: hdl/write_payload_aligner.sv
// write payload aligner: half-beat stitching into dw ordered fifo words, flush, back-pressure

`timescale 1ns/1ps

module write_payload_aligner (
   input  logic                              clk,
   input  logic                              rst_n,
   input  rx_engine_pkg::pay_beat_t          pay_beat_i,
   input  logic                              pay_valid_i,
   output logic                              pay_ready_o,
   output logic [rx_engine_pkg::DATA_W-1:0]  fifo_word_o,
   output logic                              fifo_valid_o,
   input  logic                              fifo_ready_i
);

   localparam int HALF_W = rx_engine_pkg::DATA_W / 2;
   localparam int SLOTS  = rx_engine_pkg::DATA_W / rx_engine_pkg::DW_W;

   logic [HALF_W-1:0]                hold_q;     // upper half of previous beat
   logic [rx_engine_pkg::LEN_W-1:0]  rem_q;      // dws left, counted from hold_q
   logic [rx_engine_pkg::DATA_W-1:0] word_q;
   logic                             valid_q;
   logic                             flush_q;    // held half still owed after tlast
   logic                             pay_acc;
   logic                             word_take;
   logic                             word_load;
   logic [rx_engine_pkg::DATA_W-1:0] word_nxt;
   logic [HALF_W-1:0]                pay_lo;
   logic [HALF_W-1:0]                pay_hi;

   // zero every dw slot at or past n_dw
   function automatic logic [rx_engine_pkg::DATA_W-1:0] dw_mask(
      input logic [rx_engine_pkg::DATA_W-1:0] word,
      input logic [rx_engine_pkg::LEN_W-1:0]  n_dw
   );
      logic [rx_engine_pkg::DATA_W-1:0] res;
      res = '0;
      for (int i = 0; i < SLOTS; i++) begin
         if (i < int'(n_dw)) begin
            res[i*rx_engine_pkg::DW_W +: rx_engine_pkg::DW_W] =
               word[i*rx_engine_pkg::DW_W +: rx_engine_pkg::DW_W];
         end
      end
      return res;
   endfunction

   assign pay_lo = pay_beat_i.data[HALF_W-1:0];
   assign pay_hi = pay_beat_i.data[rx_engine_pkg::DATA_W-1 -: HALF_W];

   assign pay_ready_o = !valid_q && !flush_q;  // one word in flight at most
   assign pay_acc     = pay_valid_i && pay_ready_o;
   assign word_take   = valid_q && fifo_ready_i;

   ///////////////////////////////////////////////////////////////////////
   // next word select
   ///////////////////////////////////////////////////////////////////////
   always_comb begin
      word_load = 1'b0;
      word_nxt  = '0;
      if (word_take && flush_q) begin
         word_load = 1'b1;  // tail dws, straight after the previous word
         word_nxt  = dw_mask({{HALF_W{1'b0}}, hold_q}, rem_q);
      end else if (pay_acc) begin
         if (pay_beat_i.first) begin
            if (pay_beat_i.len <= rx_engine_pkg::LEN_W'(4)) begin
               word_load = 1'b1;  // whole write sits in the header beat
               word_nxt  = dw_mask({{HALF_W{1'b0}}, pay_hi}, pay_beat_i.len);
            end
         end else begin
            word_load = 1'b1;
            word_nxt  = dw_mask({pay_lo, hold_q}, rem_q);
         end
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // control
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         flush_q <= 1'b0;
         rem_q   <= '0;
      end else begin
         if (word_load) begin
            valid_q <= 1'b1;
         end else if (word_take) begin
            valid_q <= 1'b0;
         end

         if (word_take) begin
            flush_q <= 1'b0;
         end else if (pay_acc && !pay_beat_i.first) begin
            // tail left in the upper half
            flush_q <= pay_beat_i.last && (rem_q > rx_engine_pkg::LEN_W'(8));
         end

         if (pay_acc) begin
            if (pay_beat_i.first) begin
               rem_q <= pay_beat_i.len;
            end else if (rem_q > rx_engine_pkg::LEN_W'(8)) begin
               rem_q <= rem_q - rx_engine_pkg::LEN_W'(8);
            end else begin
               rem_q <= '0;
            end
         end
      end
   end

   // data path
   always_ff @(posedge clk) begin
      if (pay_acc) begin
         hold_q <= pay_hi;
      end
      if (word_load) begin
         word_q <= word_nxt;
      end
   end

   assign fifo_word_o  = word_q;
   assign fifo_valid_o = valid_q;

   a_fifo_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      fifo_valid_o && !fifo_ready_i |=> fifo_valid_o && $stable(fifo_word_o)
   ) else $error("fifo word changed before it was accepted");

endmodule

// File: run_sim.sh
#!/bin/sh
# build the rx engine testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_rx_engine -f rx_engine_top.f

out=$(./obj_dir/Vtb_rx_engine)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
   echo "simulation passed"
else
   echo "simulation reported a failure"
   exit 1
fi

// File: rx_engine_top.f
hdl/rx_engine_pkg.sv
hdl/cq_request_decoder.sv
hdl/write_payload_aligner.sv
hdl/throughput_meter.sv
hdl/rx_engine_top.sv
tb/tb_rx_engine.sv

// File: tb/tb_rx_engine.sv
// testbench for rx_engine_top: idle state, reads, writes with back-pressure, throughput windows

`timescale 1ns/1ps

module tb_rx_engine;

   localparam int WINDOW_CYCLES = 63;   // 64 cycle windows
   localparam int TMO           = 200;  // cycles allowed per wait loop

   logic                             clk;
   logic                             rst_n;
   rx_engine_pkg::cq_beat_t          cq_beat_i;
   logic                             cq_valid_i;
   logic                             cq_ready_o;
   rx_engine_pkg::compl_req_t        compl_req_o;
   logic                             compl_valid_o;
   logic                             compl_ready_i;
   logic [rx_engine_pkg::DATA_W-1:0] fifo_word_o;
   logic                             fifo_valid_o;
   logic                             fifo_ready_i;
   logic                             meter_clear_i;
   logic [31:0]                      window_count_o;
   logic                             window_done_o;

   integer      seed;
   int          value_errs;
   int          other_errs;
   logic [31:0] dws [0:63];                                // payload of the current write
   logic [rx_engine_pkg::DATA_W-1:0] exp_words [$];  // words still owed by the dut

   initial clk = 1'b0;
   always #4 clk = ~clk;

   rx_engine_top #(
      .WINDOW_CYCLES (WINDOW_CYCLES)
   ) i_rx_engine_top (
      .clk            (clk),
      .rst_n          (rst_n),
      .cq_beat_i      (cq_beat_i),
      .cq_valid_i     (cq_valid_i),
      .cq_ready_o     (cq_ready_o),
      .compl_req_o    (compl_req_o),
      .compl_valid_o  (compl_valid_o),
      .compl_ready_i  (compl_ready_i),
      .fifo_word_o    (fifo_word_o),
      .fifo_valid_o   (fifo_valid_o),
      .fifo_ready_i   (fifo_ready_i),
      .meter_clear_i  (meter_clear_i),
      .window_count_o (window_count_o),
      .window_done_o  (window_done_o)
   );

   //////////////////////////////////////////////////////////////////////
   // reporting and stimulus helpers
   //////////////////////////////////////////////////////////////////////
   task automatic report_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
      value_errs++;
      $display("Fail %s: got %0h expected %0h", name, got, exp);
   endtask

   task automatic report_other(input string msg);
      other_errs++;
      $display("Error: %s", msg);
   endtask

   // lower 128 bits of a header beat
   function automatic logic [127:0] make_hdr(
      input logic [3:0]  typ,
      input logic [10:0] len,
      input logic [10:0] addr,
      input logic [15:0] rid,
      input logic [7:0]  tag,
      input logic [2:0]  tc,
      input logic [2:0]  attr
   );
      logic [127:0] h;
      h = '0;
      h[rx_engine_pkg::HDR_ADDR_LSB +: 11] = addr;
      h[rx_engine_pkg::HDR_LEN_LSB +: rx_engine_pkg::LEN_W] = len;
      h[rx_engine_pkg::HDR_TYPE_LSB +: 4] = typ;
      h[rx_engine_pkg::HDR_RID_LSB +: 16] = rid;
      h[rx_engine_pkg::HDR_TAG_LSB +: 8] = tag;
      h[rx_engine_pkg::HDR_TC_LSB +: 3] = tc;
      h[rx_engine_pkg::HDR_ATTR_LSB +: 3] = attr;
      return h;
   endfunction

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send_beat(input rx_engine_pkg::cq_beat_t b);
      int n;
      n = 0;
      cq_beat_i  = b;
      cq_valid_i = 1'b1;
      #1;
      while (!cq_ready_o && n < TMO) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (!cq_ready_o) report_other("cq_ready_o never rose for a request beat");
      @(negedge clk);  // beat taken on the rising edge in between
      cq_valid_i = 1'b0;
   endtask

   // fifo side, optionally random ready, compares every accepted word
   task automatic collect_words(input int n_words, input bit rand_ready);
      logic [31:0]  r;
      logic [255:0] exp;
      int           got;
      int           n;
      got = 0;
      n   = 0;
      while (got < n_words && n < TMO) begin
         @(negedge clk);
         n++;
         r = $random(seed);
         fifo_ready_i = rand_ready ? r[0] : 1'b1;
         if (fifo_valid_o && cq_ready_o) report_other("cq_ready_o high while a fifo word is held");
         if (fifo_valid_o && fifo_ready_i) begin  // taken on the next rising edge
            exp = exp_words.pop_front();
            if (fifo_word_o !== exp) report_value("fifo_word_o", fifo_word_o, exp);
            got++;
         end
      end
      if (got < n_words) report_other("timed out waiting for fifo words");
   endtask

   //////////////////////////////////////////////////////////////////////
   // tests
   //////////////////////////////////////////////////////////////////////
   task automatic check_idle();
      if (compl_valid_o !== 1'b0) report_value("compl_valid_o", 256'(compl_valid_o), 256'(0));
      if (fifo_valid_o !== 1'b0) report_value("fifo_valid_o", 256'(fifo_valid_o), 256'(0));
      if (window_done_o !== 1'b0) report_value("window_done_o", 256'(window_done_o), 256'(0));
      if (cq_ready_o !== 1'b1) report_value("cq_ready_o", 256'(cq_ready_o), 256'(1));
   endtask

   task automatic test_read_one();
      rx_engine_pkg::cq_beat_t   b;
      rx_engine_pkg::compl_req_t exp;
      logic [31:0]               r0;
      logic [31:0]               r1;
      r0 = $random(seed);
      r1 = $random(seed);
      b  = '0;
      b.data[127:0] = make_hdr(rx_engine_pkg::REQ_MEM_RD, 11'd1, r0[10:0], r0[31:16],
                               r1[7:0], r1[10:8], r1[13:11]);
      b.last    = 1'b1;
      b.byte_en = r1[23:16];
      exp.tc    = r1[10:8];  // expected fields straight from the header layout
      exp.attr  = r1[13:11];
      exp.len   = 11'd1;
      exp.rid   = r0[31:16];
      exp.tag   = r1[7:0];
      exp.be    = r1[23:16];
      exp.addr  = r0[10:0];
      if (compl_valid_o !== 1'b0) report_value("compl_valid_o", 256'(compl_valid_o), 256'(0));
      send_beat(b);
      // completion side stalls for a while
      for (int i = 0; i < 5; i++) begin
         if (compl_valid_o !== 1'b1) report_value("compl_valid_o", 256'(compl_valid_o), 256'(1));
         if (cq_ready_o !== 1'b0) report_value("cq_ready_o", 256'(cq_ready_o), 256'(0));
         if (compl_req_o !== exp) report_value("compl_req_o", 256'(compl_req_o), 256'(exp));
         @(negedge clk);
      end
      compl_ready_i = 1'b1;
      @(negedge clk);
      compl_ready_i = 1'b0;
      if (compl_valid_o !== 1'b0) report_value("compl_valid_o", 256'(compl_valid_o), 256'(0));
      if (cq_ready_o !== 1'b1) report_value("cq_ready_o", 256'(cq_ready_o), 256'(1));
   endtask

   task automatic test_read_two();
      rx_engine_pkg::cq_beat_t b;
      b = '0;
      b.data[127:0] = make_hdr(rx_engine_pkg::REQ_MEM_RD, 11'd2, 11'h12, 16'hbeef,
                               8'h21, 3'd1, 3'd2);
      b.last    = 1'b1;
      b.byte_en = 8'hff;
      send_beat(b);
      for (int i = 0; i < 6; i++) begin  // must be swallowed silently
         if (compl_valid_o !== 1'b0) report_value("compl_valid_o", 256'(compl_valid_o), 256'(0));
         @(negedge clk);
      end
      if (cq_ready_o !== 1'b1) report_value("cq_ready_o", 256'(cq_ready_o), 256'(1));
   endtask

   task automatic run_write(input int len, input bit rand_ready);
      rx_engine_pkg::cq_beat_t b;
      logic [255:0]            w;
      int                      n_words;
      int                      n_beats;
      for (int i = 0; i < 64; i++) begin
         dws[i] = $random(seed);  // slots past len carry junk
      end
      // word n holds dw 8n..8n+7, lowest dw in bits 31:0
      n_words = (len + 7) / 8;
      for (int n = 0; n < n_words; n++) begin
         w = '0;
         for (int k = 0; k < 8; k++) begin
            if (8*n + k < len) w[32*k +: 32] = dws[8*n + k];
         end
         exp_words.push_back(w);
      end
      n_beats = (len > 4) ? 1 + (len - 4 + 7) / 8 : 1;
      fork
         begin
            for (int j = 0; j < n_beats; j++) begin
               b         = '0;
               b.byte_en = 8'hff;
               b.last    = (j == n_beats - 1);
               if (j == 0) begin
                  b.data[127:0] = make_hdr(rx_engine_pkg::REQ_MEM_WR, 11'(len), 11'h40,
                                           16'h0100, 8'h05, 3'd0, 3'd0);
                  for (int k = 0; k < 4; k++) b.data[128 + 32*k +: 32] = dws[k];
               end else begin
                  for (int k = 0; k < 8; k++) b.data[32*k +: 32] = dws[8*j - 4 + k];
               end
               send_beat(b);
            end
         end
         collect_words(n_words, rand_ready);
      join
      fifo_ready_i = 1'b1;
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         if (fifo_valid_o) report_other($sformatf("extra fifo word after write of %0d dw", len));
      end
   endtask

   task automatic test_throughput();
      int total;
      int sum;
      int cyc;
      int last_pulse;
      bit sent_done;
      bit idle_seen;
      total      = (20 + 7) / 8 + (12 + 7) / 8 + (8 + 7) / 8 + (3 + 7) / 8;
      sum        = 0;
      cyc        = 0;
      last_pulse = -1;
      sent_done  = 1'b0;
      idle_seen  = 1'b0;
      @(negedge clk);
      meter_clear_i = 1'b1;
      @(negedge clk);
      meter_clear_i = 1'b0;
      fork
         begin
            run_write(20, 1'b1);
            run_write(12, 1'b1);
            run_write(8, 1'b0);
            run_write(3, 1'b0);
            sent_done = 1'b1;
         end
         begin
            while (!idle_seen && cyc < 2000) begin
               @(negedge clk);
               cyc++;
               if (window_done_o) begin
                  if (last_pulse >= 0 && cyc - last_pulse != WINDOW_CYCLES + 1) begin
                     report_other($sformatf("window pulses %0d cycles apart", cyc - last_pulse));
                  end
                  last_pulse = cyc;
                  sum = sum + int'(window_count_o);
                  if (sent_done && window_count_o == 32'd0) idle_seen = 1'b1;
               end
            end
            if (!idle_seen) report_other("no idle throughput window was reported");
         end
      join
      if (sum != total) report_value("window_count_o", 256'(sum), 256'(total));
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      seed          = 89771;
      value_errs    = 0;
      other_errs    = 0;
      rst_n         = 1'b0;
      cq_beat_i     = '0;
      cq_valid_i    = 1'b0;
      compl_ready_i = 1'b0;
      fifo_ready_i  = 1'b0;
      meter_clear_i = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_idle();
      test_read_one();
      test_read_one();
      test_read_two();
      for (int len = 1; len <= 4; len++) run_write(len, 1'b0);  // header-only writes
      run_write(5, 1'b1);
      run_write(8, 1'b1);
      run_write(12, 1'b1);
      run_write(20, 1'b1);
      test_throughput();
      $display("errors: %0d value, %0d other", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
